// ==== include/fu_exec_cfg.svh ====
`ifndef FU_EXEC_CFG_SVH
`define FU_EXEC_CFG_SVH

// Operand and result width, tied to the 64-bit memory access
`define FU_WORD_BITS 64

// Width of a reorder buffer index
`define FU_ROB_IDX_BITS 5

// Data memory size in bytes, must be a power of two
`define FU_DMEM_BYTES 4096

`endif

// ==== design/fu_pkg.sv ====
`include "fu_exec_cfg.svh"

package fu_pkg;

  typedef enum logic [3:0] {
    PLUS,
    PLUS_SIGNED,
    MINUS,
    ORN,
    OR,
    EOR,
    AND,
    CSNEG,
    CSINC,
    CSINV,
    CSEL,
    MOV,
    PASS_A,
    LDUR,
    STUR
  } fu_op_t;

  // ARM condition code encoding
  typedef enum logic [3:0] {
    EQ, NE, CS, CC, MI, PL, VS, VC,
    HI, LS, GE, LT, GT, LE, AL, NV
  } cond_t;

  typedef struct packed {
    logic n;
    logic z;
    logic c;
    logic v;
  } nzcv_t;

  typedef struct packed {
    fu_op_t                      op;
    logic [`FU_WORD_BITS-1:0]    val_a;
    logic [`FU_WORD_BITS-1:0]    val_b;
    logic [`FU_ROB_IDX_BITS-1:0] rob_idx;
    logic                        set_nzcv;
    nzcv_t                       nzcv;
    cond_t                       cond;
  } alu_issue_t;

  // val_a is the address, val_b the store data
  typedef struct packed {
    fu_op_t                      op;
    logic [`FU_WORD_BITS-1:0]    val_a;
    logic [`FU_WORD_BITS-1:0]    val_b;
    logic [`FU_ROB_IDX_BITS-1:0] rob_idx;
  } ls_issue_t;

  typedef struct packed {
    fu_op_t                      op;
    logic [`FU_WORD_BITS-1:0]    val_a;
    logic [`FU_WORD_BITS-1:0]    val_b;
    logic [`FU_ROB_IDX_BITS-1:0] rob_idx;
    logic                        set_nzcv;
    nzcv_t                       nzcv;
    cond_t                       cond;
    logic                        is_alu;
  } exec_slot_t;

  typedef struct packed {
    logic [`FU_ROB_IDX_BITS-1:0] rob_idx;
    logic [`FU_WORD_BITS-1:0]    value;
    logic                        set_nzcv;
    nzcv_t                       nzcv;
    logic                        cond_holds;
  } rob_result_t;

endpackage

// ==== design/fu_issue_latch.sv ====
`timescale 1ns/1ps

module fu_issue_latch (
  input  logic               clk,
  input  logic               reset,
  input  logic               alu_start,
  input  fu_pkg::alu_issue_t alu_issue,
  input  logic               ls_start,
  input  fu_pkg::ls_issue_t  ls_issue,
  output logic               alu_ready,
  output logic               ls_ready,
  output fu_pkg::exec_slot_t slot,
  output logic               slot_valid
);

  // Each unit is busy for the one cycle after its start
  always_ff @(posedge clk) begin
    if (reset) begin
      slot_valid <= 1'b0;
      alu_ready  <= 1'b1;
      ls_ready   <= 1'b1;
    end else begin
      slot_valid <= alu_start | ls_start;
      alu_ready  <= ~alu_start;
      ls_ready   <= ~ls_start;
    end
  end

  // ALU issue wins when both strobes are high
  always_ff @(posedge clk) begin
    if (alu_start) begin
      slot.op       <= alu_issue.op;
      slot.val_a    <= alu_issue.val_a;
      slot.val_b    <= alu_issue.val_b;
      slot.rob_idx  <= alu_issue.rob_idx;
      slot.set_nzcv <= alu_issue.set_nzcv;
      slot.nzcv     <= alu_issue.nzcv;
      slot.cond     <= alu_issue.cond;
      slot.is_alu   <= 1'b1;
    end else if (ls_start) begin
      slot.op       <= ls_issue.op;
      slot.val_a    <= ls_issue.val_a;
      slot.val_b    <= ls_issue.val_b;
      slot.rob_idx  <= ls_issue.rob_idx;
      // Memory ops carry no flags
      slot.set_nzcv <= 1'b0;
      slot.nzcv     <= '0;
      slot.cond     <= fu_pkg::AL;
      slot.is_alu   <= 1'b0;
    end
  end

  // Load/store station must yield the cycle to the ALU station
  ls_alu_exclusive: assert property (
    @(posedge clk) disable iff (reset) !(ls_start && alu_start)
  ) else $error("load/store start in the same cycle as ALU start");

  // Stations start only on a high ready level
  ls_start_ready: assert property (
    @(posedge clk) disable iff (reset) ls_start |-> ls_ready
  ) else $error("load/store start while ls_ready is low");

  alu_start_ready: assert property (
    @(posedge clk) disable iff (reset) alu_start |-> alu_ready
  ) else $error("ALU start while alu_ready is low");

endmodule

// ==== design/fu_cond_eval.sv ====
`timescale 1ns/1ps

module fu_cond_eval (
  input  fu_pkg::cond_t cond,
  input  fu_pkg::nzcv_t nzcv,
  output logic          holds
);

  logic hi;
  logic ge;
  logic gt;

  // Compound terms shared by the paired codes
  assign hi = nzcv.c & ~nzcv.z;
  assign ge = (nzcv.n == nzcv.v);
  assign gt = ~nzcv.z & ge;

  always_comb begin
    case (cond)
      fu_pkg::EQ: holds = nzcv.z;
      fu_pkg::NE: holds = ~nzcv.z;
      fu_pkg::CS: holds = nzcv.c;
      fu_pkg::CC: holds = ~nzcv.c;
      fu_pkg::MI: holds = nzcv.n;
      fu_pkg::PL: holds = ~nzcv.n;
      fu_pkg::VS: holds = nzcv.v;
      fu_pkg::VC: holds = ~nzcv.v;
      fu_pkg::HI: holds = hi;
      fu_pkg::LS: holds = ~hi;
      fu_pkg::GE: holds = ge;
      fu_pkg::LT: holds = ~ge;
      fu_pkg::GT: holds = gt;
      fu_pkg::LE: holds = ~gt;
      // AL and NV both always hold
      default:    holds = 1'b1;
    endcase
  end

endmodule

// ==== design/fu_alu.sv ====
`timescale 1ns/1ps

`include "fu_exec_cfg.svh"

module fu_alu (
  input  fu_pkg::exec_slot_t       slot,
  input  logic                     cond_holds,
  output logic [`FU_WORD_BITS-1:0] value,
  output fu_pkg::nzcv_t            nzcv
);

  localparam int W = `FU_WORD_BITS;

  logic [W-1:0] a;
  logic [W-1:0] b;
  logic [W:0]   sum;
  logic [W:0]   diff;
  logic         add_ovf;
  logic         sub_ovf;

  assign a = slot.val_a;
  assign b = slot.val_b;

  // Extra top bit holds carry out or borrow
  assign sum  = {1'b0, a} + {1'b0, b};
  assign diff = {1'b0, a} - {1'b0, b};

  // Same-sign add or mixed-sign subtract that flips the sign of a
  assign add_ovf = (a[W-1] == b[W-1]) && (sum[W-1] != a[W-1]);
  assign sub_ovf = (a[W-1] != b[W-1]) && (diff[W-1] != a[W-1]);

  always_comb begin
    case (slot.op)
      fu_pkg::PLUS,
      fu_pkg::PLUS_SIGNED: value = sum[W-1:0];
      fu_pkg::MINUS:       value = diff[W-1:0];
      fu_pkg::ORN:         value = a | ~b;
      fu_pkg::OR,
      fu_pkg::MOV:         value = a | b;
      fu_pkg::EOR:         value = a ^ b;
      fu_pkg::AND:         value = a & b;
      fu_pkg::PASS_A:      value = a;
      fu_pkg::CSEL:        value = cond_holds ? a : b;
      fu_pkg::CSINC:       value = cond_holds ? a : b + 1'b1;
      fu_pkg::CSINV:       value = cond_holds ? a : ~b;
      fu_pkg::CSNEG:       value = cond_holds ? a : ~b + 1'b1;
      default:             value = '0;
    endcase
  end

  always_comb begin
    nzcv = slot.nzcv;
    if (slot.set_nzcv) begin
      nzcv.n = value[W-1];
      nzcv.z = (value == '0);
      nzcv.c = 1'b0;
      nzcv.v = 1'b0;
      case (slot.op)
        fu_pkg::PLUS,
        fu_pkg::PLUS_SIGNED: begin
          nzcv.c = sum[W];
          nzcv.v = add_ovf;
        end
        fu_pkg::MINUS: begin
          // No borrow means a >= b unsigned
          nzcv.c = ~diff[W];
          nzcv.v = sub_ovf;
        end
        default: begin
        end
      endcase
    end
  end

  // ALU-tagged slots come only from the ALU station, never with memory opcodes
  always_comb begin
    alu_op_legal: assert final (
      !(slot.is_alu === 1'b1 && slot.op inside {fu_pkg::LDUR, fu_pkg::STUR})
    ) else $error("memory opcode %s issued on the ALU path", slot.op.name());
  end

endmodule

// ==== design/fu_dmem.sv ====
`timescale 1ns/1ps

`include "fu_exec_cfg.svh"

module fu_dmem (
  input  logic                     clk,
  input  fu_pkg::exec_slot_t       slot,
  input  logic                     slot_valid,
  output logic [`FU_WORD_BITS-1:0] rdata
);

  localparam int ADDR_BITS  = $clog2(`FU_DMEM_BYTES);
  localparam int WORD_BYTES = `FU_WORD_BITS / 8;

  logic [7:0]           mem [`FU_DMEM_BYTES];
  logic [ADDR_BITS-1:0] base;
  logic                 wr_en;

  // Address taken modulo the memory size
  assign base  = slot.val_a[ADDR_BITS-1:0];
  assign wr_en = slot_valid && (slot.op == fu_pkg::STUR);

  // Little-endian read, byte offsets wrap around the top of memory
  always_comb begin
    for (int i = 0; i < WORD_BYTES; i++) begin
      rdata[8*i +: 8] = mem[ADDR_BITS'(base + i)];
    end
  end

  // Store lands at the edge closing the store cycle
  always_ff @(posedge clk) begin
    if (wr_en) begin
      for (int i = 0; i < WORD_BYTES; i++) begin
        mem[ADDR_BITS'(base + i)] <= slot.val_b[8*i +: 8];
      end
    end
  end

endmodule

// ==== design/fu_result_mux.sv ====
`timescale 1ns/1ps

`include "fu_exec_cfg.svh"

module fu_result_mux (
  input  fu_pkg::exec_slot_t       slot,
  input  logic                     slot_valid,
  input  logic [`FU_WORD_BITS-1:0] alu_value,
  input  fu_pkg::nzcv_t            alu_nzcv,
  input  logic                     cond_holds,
  input  logic [`FU_WORD_BITS-1:0] mem_rdata,
  output logic                     done,
  output fu_pkg::rob_result_t      result
);

  // One item in flight, so the slot valid bit is the done pulse
  assign done = slot_valid;

  always_comb begin
    result.rob_idx = slot.rob_idx;
    if (slot.is_alu) begin
      result.value      = alu_value;
      result.set_nzcv   = slot.set_nzcv;
      result.nzcv       = alu_nzcv;
      result.cond_holds = cond_holds;
    end else begin
      // Loads return memory data, stores echo their data
      result.value      = (slot.op == fu_pkg::LDUR) ? mem_rdata : slot.val_b;
      result.set_nzcv   = 1'b0;
      result.nzcv       = '0;
      result.cond_holds = 1'b0;
    end
  end

endmodule

// ==== design/fu_exec_top.sv ====
`timescale 1ns/1ps

`include "fu_exec_cfg.svh"

module fu_exec_top (
  input  logic                clk,
  input  logic                reset,
  input  logic                alu_start,
  input  fu_pkg::alu_issue_t  alu_issue,
  input  logic                ls_start,
  input  fu_pkg::ls_issue_t   ls_issue,
  output logic                alu_ready,
  output logic                ls_ready,
  output logic                done,
  output fu_pkg::rob_result_t result
);

  fu_pkg::exec_slot_t       slot;
  logic                     slot_valid;
  logic                     cond_holds;
  logic [`FU_WORD_BITS-1:0] alu_value;
  fu_pkg::nzcv_t            alu_nzcv;
  logic [`FU_WORD_BITS-1:0] mem_rdata;

  fu_issue_latch i_issue_latch (
    .clk        (clk),
    .reset      (reset),
    .alu_start  (alu_start),
    .alu_issue  (alu_issue),
    .ls_start   (ls_start),
    .ls_issue   (ls_issue),
    .alu_ready  (alu_ready),
    .ls_ready   (ls_ready),
    .slot       (slot),
    .slot_valid (slot_valid)
  );

  fu_cond_eval i_cond_eval (.cond(slot.cond), .nzcv(slot.nzcv), .holds(cond_holds));

  fu_alu i_alu (.slot(slot), .cond_holds(cond_holds), .value(alu_value), .nzcv(alu_nzcv));

  fu_dmem i_dmem (.clk(clk), .slot(slot), .slot_valid(slot_valid), .rdata(mem_rdata));

  fu_result_mux i_result_mux (
    .slot       (slot),
    .slot_valid (slot_valid),
    .alu_value  (alu_value),
    .alu_nzcv   (alu_nzcv),
    .cond_holds (cond_holds),
    .mem_rdata  (mem_rdata),
    .done       (done),
    .result     (result)
  );

endmodule

// ==== verif/fu_exec_tb.sv ====
`timescale 1ns/1ps

`include "fu_exec_cfg.svh"

module fu_exec_tb;

  localparam int W        = `FU_WORD_BITS;
  localparam int IDXW     = `FU_ROB_IDX_BITS;
  localparam int N_RANDOM = 200;
  localparam logic [W-1:0] ONES    = '1;
  localparam logic [W-1:0] MAX_POS = {1'b0, {(W-1){1'b1}}};
  localparam logic [W-1:0] MIN_NEG = {1'b1, {(W-1){1'b0}}};

  // One issue with its unit and the record the ROB should see
  typedef struct packed {
    logic                is_alu;
    fu_pkg::alu_issue_t  alu;
    fu_pkg::ls_issue_t   ls;
    fu_pkg::rob_result_t exp;
  } stim_t;

  logic                clk;
  logic                reset;
  logic                alu_start;
  fu_pkg::alu_issue_t  alu_issue;
  logic                ls_start;
  fu_pkg::ls_issue_t   ls_issue;
  logic                alu_ready;
  logic                ls_ready;
  logic                done;
  fu_pkg::rob_result_t result;

  stim_t  stim[$];
  integer seed;

  fu_exec_top i_dut (.*);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // Reset, two cycles per issue and some margin
  initial begin
    int limit;
    #1;
    limit = 5 + 2 * (stim.size() + N_RANDOM) + 20;
    repeat (limit) @(posedge clk);
    $display("timeout: the test did not finish within %0d cycles", limit);
    $display("=== FAIL ===");
    $fatal(1, "watchdog expired");
  end

  task automatic report_mismatch(input string msg);
    $display("mismatch at %0t: %s", $time, msg);
    $display("=== FAIL ===");
    $fatal(1, "check failed");
  endtask

  function automatic string result_text(input fu_pkg::rob_result_t r);
    return $sformatf("idx %0d value %h set %b nzcv %b holds %b",
                     r.rob_idx, r.value, r.set_nzcv, r.nzcv, r.cond_holds);
  endfunction

  task automatic check_result(input fu_pkg::rob_result_t got, input fu_pkg::rob_result_t exp,
                              input string what);
    if (got !== exp) begin
      report_mismatch($sformatf("%s: got %s, expected %s", what, result_text(got),
                                result_text(exp)));
    end
  endtask

  task automatic check_ready(input logic got_alu, input logic got_ls, input logic exp_alu,
                             input logic exp_ls, input string what);
    if (got_alu !== exp_alu || got_ls !== exp_ls) begin
      report_mismatch($sformatf("%s: ready alu %b ls %b, expected alu %b ls %b",
                                what, got_alu, got_ls, exp_alu, exp_ls));
    end
  endtask

  task automatic check_done(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      report_mismatch($sformatf("%s: done %b, expected %b", what, got, exp));
    end
  endtask

  // Codes pair up as a test and its inverse, except the last pair
  function automatic logic cond_ref(input fu_pkg::cond_t cond, input fu_pkg::nzcv_t f);
    logic [3:0] code;
    logic       base;
    code = cond;
    case (code[3:1])
      3'd0:    base = f.z;
      3'd1:    base = f.c;
      3'd2:    base = f.n;
      3'd3:    base = f.v;
      3'd4:    base = f.c & ~f.z;
      3'd5:    base = (f.n == f.v);
      3'd6:    base = ~f.z & (f.n == f.v);
      default: base = 1'b1;
    endcase
    return (code[3:1] == 3'd7) ? 1'b1 : base ^ code[0];
  endfunction

  function automatic fu_pkg::rob_result_t alu_ref(input fu_pkg::alu_issue_t iss);
    fu_pkg::rob_result_t r;
    logic [W-1:0]        a;
    logic [W-1:0]        b;
    logic                holds;
    a     = iss.val_a;
    b     = iss.val_b;
    holds = cond_ref(iss.cond, iss.nzcv);
    case (iss.op)
      fu_pkg::PLUS, fu_pkg::PLUS_SIGNED: r.value = a + b;
      fu_pkg::MINUS:                     r.value = a - b;
      fu_pkg::ORN:                       r.value = a | ~b;
      fu_pkg::OR, fu_pkg::MOV:           r.value = a | b;
      fu_pkg::EOR:                       r.value = a ^ b;
      fu_pkg::AND:                       r.value = a & b;
      fu_pkg::CSEL:                      r.value = holds ? a : b;
      fu_pkg::CSINC:                     r.value = holds ? a : b + W'(1);
      fu_pkg::CSINV:                     r.value = holds ? a : ~b;
      fu_pkg::CSNEG:                     r.value = holds ? a : -b;
      default:                           r.value = a;
    endcase
    r.rob_idx    = iss.rob_idx;
    r.set_nzcv   = iss.set_nzcv;
    r.cond_holds = holds;
    r.nzcv       = iss.nzcv;
    if (iss.set_nzcv) begin
      r.nzcv.n = r.value[W-1];
      r.nzcv.z = (r.value == '0);
      r.nzcv.c = 1'b0;
      r.nzcv.v = 1'b0;
      if (iss.op == fu_pkg::PLUS || iss.op == fu_pkg::PLUS_SIGNED) begin
        // Unsigned sum wrapped below an operand
        r.nzcv.c = (r.value < a);
        r.nzcv.v = ({a[W-1], a} + {b[W-1], b}) != {r.value[W-1], r.value};
      end else if (iss.op == fu_pkg::MINUS) begin
        r.nzcv.c = (a >= b);
        r.nzcv.v = ({a[W-1], a} - {b[W-1], b}) != {r.value[W-1], r.value};
      end
    end
    return r;
  endfunction

  task automatic alu_row(input fu_pkg::fu_op_t op, input logic [W-1:0] a, input logic [W-1:0] b,
                         input logic set, input fu_pkg::nzcv_t flags, input fu_pkg::cond_t cond,
                         input logic [W-1:0] value, input fu_pkg::nzcv_t nzcv, input logic holds);
    stim_t s;
    s        = '0;
    s.is_alu = 1'b1;
    s.alu    = '{op, a, b, IDXW'(stim.size()), set, flags, cond};
    s.exp    = '{IDXW'(stim.size()), value, set, nzcv, holds};
    stim.push_back(s);
  endtask

  task automatic mem_row(input fu_pkg::fu_op_t op, input logic [W-1:0] addr,
                         input logic [W-1:0] data, input logic [W-1:0] value);
    stim_t s;
    s        = '0;
    s.is_alu = 1'b0;
    s.ls     = '{op, addr, data, IDXW'(stim.size())};
    s.exp    = '{IDXW'(stim.size()), value, 1'b0, 4'b0000, 1'b0};
    stim.push_back(s);
  endtask

  task automatic fill_table();
    // Carry, overflow, zero and negative edges
    alu_row(fu_pkg::PLUS, ONES, 64'd1, 1'b1, 4'b0000, fu_pkg::AL, 64'd0, 4'b0110, 1'b1);
    alu_row(fu_pkg::PLUS, MAX_POS, 64'd1, 1'b1, 4'b0000, fu_pkg::AL, MIN_NEG, 4'b1001, 1'b1);
    alu_row(fu_pkg::MINUS, 64'd3, 64'd5, 1'b1, 4'b0000, fu_pkg::AL, -64'd2, 4'b1000, 1'b1);
    alu_row(fu_pkg::MINUS, 64'd9, 64'd9, 1'b1, 4'b0000, fu_pkg::AL, 64'd0, 4'b0110, 1'b1);
    alu_row(fu_pkg::MINUS, MIN_NEG, 64'd1, 1'b1, 4'b0000, fu_pkg::AL, MAX_POS, 4'b0011, 1'b1);
    // Flags pass through with set_nzcv low
    alu_row(fu_pkg::PLUS_SIGNED, 64'd10, 64'd20, 1'b0, 4'b1010, fu_pkg::AL, 64'd30, 4'b1010,
            1'b1);
    alu_row(fu_pkg::ORN, 64'h100, ~64'hf, 1'b1, 4'b0000, fu_pkg::AL, 64'h10f, 4'b0000, 1'b1);
    alu_row(fu_pkg::EOR, 64'hff, 64'hff, 1'b1, 4'b0000, fu_pkg::AL, 64'd0, 4'b0100, 1'b1);
    alu_row(fu_pkg::AND, 64'hf0f0, 64'hff00, 1'b1, 4'b0000, fu_pkg::AL, 64'hf000, 4'b0000, 1'b1);
    alu_row(fu_pkg::OR, 64'hf0, 64'h0f, 1'b0, 4'b0000, fu_pkg::AL, 64'hff, 4'b0000, 1'b1);
    alu_row(fu_pkg::MOV, 64'd0, 64'h1234, 1'b1, 4'b1111, fu_pkg::AL, 64'h1234, 4'b0000, 1'b1);
    alu_row(fu_pkg::PASS_A, MIN_NEG, 64'd5, 1'b1, 4'b0000, fu_pkg::AL, MIN_NEG, 4'b1000, 1'b1);
    // Conditional selects, each under a holding and a failing condition
    alu_row(fu_pkg::CSEL, 64'd11, 64'd22, 1'b0, 4'b0100, fu_pkg::EQ, 64'd11, 4'b0100, 1'b1);
    alu_row(fu_pkg::CSEL, 64'd11, 64'd22, 1'b0, 4'b0100, fu_pkg::NE, 64'd22, 4'b0100, 1'b0);
    alu_row(fu_pkg::CSINC, 64'd11, 64'd22, 1'b0, 4'b1000, fu_pkg::LT, 64'd11, 4'b1000, 1'b1);
    alu_row(fu_pkg::CSINC, 64'd11, 64'd22, 1'b0, 4'b1000, fu_pkg::GE, 64'd23, 4'b1000, 1'b0);
    alu_row(fu_pkg::CSINV, 64'd11, 64'd22, 1'b0, 4'b0010, fu_pkg::HI, 64'd11, 4'b0010, 1'b1);
    alu_row(fu_pkg::CSINV, 64'd11, 64'd22, 1'b0, 4'b0010, fu_pkg::LS, ~64'd22, 4'b0010, 1'b0);
    alu_row(fu_pkg::CSNEG, 64'd11, 64'd22, 1'b0, 4'b1001, fu_pkg::GT, 64'd11, 4'b1001, 1'b1);
    alu_row(fu_pkg::CSNEG, 64'd11, 64'd22, 1'b1, 4'b0001, fu_pkg::GT, -64'd22, 4'b1000, 1'b0);
    alu_row(fu_pkg::CSEL, 64'd11, 64'd22, 1'b0, 4'b0000, fu_pkg::NV, 64'd11, 4'b0000, 1'b1);
    // Two adjacent stores, a load across both, then a wrapped address
    mem_row(fu_pkg::STUR, 64'h40, 64'h0123_4567_89ab_cdef, 64'h0123_4567_89ab_cdef);
    mem_row(fu_pkg::STUR, 64'h48, 64'hfedc_ba98_7654_3210, 64'hfedc_ba98_7654_3210);
    mem_row(fu_pkg::LDUR, 64'h44, 64'd0, 64'h7654_3210_0123_4567);
    mem_row(fu_pkg::STUR, 64'h1080, 64'h1122_3344_5566_7788, 64'h1122_3344_5566_7788);
    mem_row(fu_pkg::LDUR, 64'h80, 64'd0, 64'h1122_3344_5566_7788);
  endtask

  // Issue on a falling edge, then check the record one cycle later
  task automatic run_issue(input stim_t s, input string what);
    @(negedge clk);
    check_done(done, 1'b0, {what, " before issue"});
    check_ready(alu_ready, ls_ready, 1'b1, 1'b1, {what, " before issue"});
    alu_start = s.is_alu;
    alu_issue = s.alu;
    ls_start  = ~s.is_alu;
    ls_issue  = s.ls;
    @(negedge clk);
    alu_start = 1'b0;
    ls_start  = 1'b0;
    check_done(done, 1'b1, what);
    check_ready(alu_ready, ls_ready, ~s.is_alu, s.is_alu, what);
    check_result(result, s.exp, what);
  endtask

  initial begin
    fu_pkg::alu_issue_t rnd;
    stim_t              s;
    seed      = 32'hd7ee;
    reset     = 1'b1;
    alu_start = 1'b0;
    alu_issue = '0;
    ls_start  = 1'b0;
    ls_issue  = '0;
    fill_table();
    repeat (5) @(negedge clk);
    reset = 1'b0;
    check_done(done, 1'b0, "after reset");
    check_ready(alu_ready, ls_ready, 1'b1, 1'b1, "after reset");
    foreach (stim[i]) begin
      run_issue(stim[i], $sformatf("table row %0d", i));
    end
    for (int i = 0; i < N_RANDOM; i++) begin
      rnd.op       = fu_pkg::fu_op_t'($unsigned($random(seed)) % 13);
      rnd.val_a    = {$random(seed), $random(seed)};
      // Every eighth issue repeats a so that equal operands get covered
      rnd.val_b    = (i % 8 == 0) ? rnd.val_a : {$random(seed), $random(seed)};
      rnd.rob_idx  = IDXW'(i);
      rnd.set_nzcv = 1'($random(seed));
      rnd.nzcv     = 4'($random(seed));
      rnd.cond     = fu_pkg::cond_t'(4'($random(seed)));
      s            = '0;
      s.is_alu     = 1'b1;
      s.alu        = rnd;
      s.exp        = alu_ref(rnd);
      run_issue(s, $sformatf("random issue %0d op %s", i, rnd.op.name()));
    end
    $display("=== PASS ===");
    $finish;
  end

endmodule

// ==== fu_exec.f ====
+incdir+include
design/fu_pkg.sv
design/fu_issue_latch.sv
design/fu_cond_eval.sv
design/fu_alu.sv
design/fu_dmem.sv
design/fu_result_mux.sv
design/fu_exec_top.sv
verif/fu_exec_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= fu_exec_tb
FILELIST  ?= fu_exec.f
OBJ_DIR   ?= obj_dir

.PHONY: sim clean

# The run exits non-zero through $fatal on any failure
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
